//--- compile.f
+incdir+source
source/rs_pkg.sv
source/cdb_if.sv
source/dispatch_bypass.sv
source/tag_wakeup.sv
source/issue_select.sv
source/rs_entry_file.sv
source/rs_mul.sv
verification/rs_mul_assertions.sv
verification/rs_mul_tb.sv

//--- verification/rs_mul_trace.txt
# D pc rd tag1 data1 rdy1 tag2 data2 rdy2 | B src valid tag data | I steps | L rs_full | T test
# E pc rd data1 data2 | F count pc rd tag1 data2 | R count pc rd data1 data2 (pc +4, rd/data2 +1)
D 00001000 11 00 aaaa0001 1 00 bbbb0001 1
E 00001000 11 aaaa0001 bbbb0001
I 1
T 1
D 00002000 21 0a 00000000 0 00 00000200 1
I 1
D 00002004 22 0b 00000000 0 00 00000204 1
I 1
D 00002008 23 00 00000208 1 0c 00000000 0
I 1
D 0000200c 24 00 0000020c 1 0d 00000000 0
I 1
B 0 1 0a a0a0a0a0
B 1 1 0b b1b1b1b1
B 2 1 0c c2c2c2c2
B 3 1 0d d3d3d3d3
E 00002000 21 a0a0a0a0 00000200
E 00002004 22 b1b1b1b1 00000204
E 00002008 23 00000208 c2c2c2c2
E 0000200c 24 0000020c d3d3d3d3
I 1
T 2
D 00003000 13 31 00000000 0 32 00000000 0
B 3 1 31 dead0003
B 1 1 31 cafe0001
B 2 1 32 dead0002
B 0 1 32 cafe0000
E 00003000 13 cafe0001 cafe0000
I 1
T 3
D 00004000 14 41 00000000 0 00 00000040 1
I 1
D 00004004 15 00 00000041 1 41 00000000 0
I 1
D 00004008 16 41 00000000 0 41 00000000 0
I 1
B 2 1 41 12345678
E 00004000 14 12345678 00000040
E 00004004 15 00000041 12345678
E 00004008 16 12345678 12345678
I 1
T 4
D 00006000 17 61 00000000 0 00 00000006 1
I 1
B 0 0 61 11111111
I 1
B 1 1 62 22222222
I 4
B 3 1 61 66666666
E 00006000 17 66666666 00000006
I 1
T 5
F 16 00005000 20 51 00005500
L 1
B 0 1 51 55555555
R 16 00005000 20 55555555 00005500
I 20
L 0
T 6

//--- verification/rs_mul_tb.sv
`default_nettype none

`include "rs_macros.svh"

module rs_mul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic          clk;
    logic          reset;
    logic          dispatch;
    rs_pkg::word_t dispatch_pc;
    rs_pkg::tag_t  dispatch_rd;
    rs_pkg::tag_t  dispatch_tag1;
    rs_pkg::tag_t  dispatch_tag2;
    rs_pkg::word_t dispatch_data1;
    rs_pkg::word_t dispatch_data2;
    logic          dispatch_rdy1;
    logic          dispatch_rdy2;
    logic          alu_valid;
    rs_pkg::tag_t  alu_tag;
    rs_pkg::word_t alu_data;
    logic          mul_valid;
    rs_pkg::tag_t  mul_tag;
    rs_pkg::word_t mul_data;
    logic          div_valid;
    rs_pkg::tag_t  div_tag;
    rs_pkg::word_t div_data;
    logic          load_valid;
    rs_pkg::tag_t  load_tag;
    rs_pkg::word_t load_data;
    logic          rs_full;
    logic          issue_valid;
    rs_pkg::word_t issue_pc;
    rs_pkg::tag_t  issue_rd;
    rs_pkg::word_t issue_data1;
    rs_pkg::word_t issue_data2;

    // inputs staged by D and B records, driven at the next step
    logic          st_dispatch;
    rs_pkg::word_t st_pc;
    rs_pkg::tag_t  st_rd;
    rs_pkg::tag_t  st_tag1;
    rs_pkg::tag_t  st_tag2;
    rs_pkg::word_t st_data1;
    rs_pkg::word_t st_data2;
    logic          st_rdy1;
    logic          st_rdy2;
    logic [3:0]    st_valid;
    rs_pkg::tag_t  st_tag [4];
    rs_pkg::word_t st_data [4];

    rs_pkg::issue_t exp_q [$];
    string          lines [$];
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;
    int             limit = 0;
    int             tests = 0;
    int             failed_tests = 0;
    int             assert_seen = 0;

    rs_mul dut0 (.*);

    bind rs_mul rs_mul_assertions asrt0 (.clk(clk), .reset(reset), .rs_full(rs_full),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_rd(issue_rd));

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        dispatch       <= st_dispatch;
        dispatch_pc    <= st_pc;
        dispatch_rd    <= st_rd;
        dispatch_tag1  <= st_tag1;
        dispatch_tag2  <= st_tag2;
        dispatch_data1 <= st_data1;
        dispatch_data2 <= st_data2;
        dispatch_rdy1  <= st_rdy1;
        dispatch_rdy2  <= st_rdy2;
        alu_valid      <= st_valid[0];
        alu_tag        <= st_tag[0];
        alu_data       <= st_data[0];
        mul_valid      <= st_valid[1];
        mul_tag        <= st_tag[1];
        mul_data       <= st_data[1];
        div_valid      <= st_valid[2];
        div_tag        <= st_tag[2];
        div_data       <= st_data[2];
        load_valid     <= st_valid[3];
        load_tag       <= st_tag[3];
        load_data      <= st_data[3];
        st_dispatch = 1'b0;
        st_valid    = '0;
    endtask

    task automatic expect_issue(input rs_pkg::word_t pc, input rs_pkg::tag_t rd,
                                input rs_pkg::word_t data1, input rs_pkg::word_t data2);
        rs_pkg::issue_t item;
        item.pc    = pc;
        item.rd    = rd;
        item.data1 = data1;
        item.data2 = data2;
        exp_q.push_back(item);
    endtask

    // fold bound assertion failures into the error count
    task automatic collect_assert_fails();
        @(negedge clk);
        errors += dut0.asrt0.fails - assert_seen;
        assert_seen = dut0.asrt0.fails;
    endtask

    // issue_valid is registered, so mid-cycle it is stable
    always @(negedge clk) begin
        rs_pkg::issue_t want;
        if (!reset && issue_valid) begin
            if (exp_q.size() == 0) begin
                $display("issue with pc %h seen while none was expected", issue_pc);
                errors++;
            end else begin
                want = exp_q.pop_front();
                checks++;
                if (issue_pc !== want.pc) begin
                    $display("[ERROR] issue_pc: got %h, expected %h", issue_pc, want.pc);
                    errors++;
                end
                if (issue_rd !== want.rd) begin
                    $display("[ERROR] issue_rd: got %h, expected %h", issue_rd, want.rd);
                    errors++;
                end
                if (issue_data1 !== want.data1) begin
                    $display("[ERROR] issue_data1: got %h, expected %h", issue_data1, want.data1);
                    errors++;
                end
                if (issue_data2 !== want.data2) begin
                    $display("[ERROR] issue_data2: got %h, expected %h", issue_data2, want.data2);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: trace did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          want;
        int          num;
        int          count;
        int          test_err;
        byte         kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        string       line;

        reset = 1'b1;
        st_dispatch = 1'b0;
        st_valid = '0;
        {st_pc, st_rd, st_tag1, st_tag2, st_data1, st_data2, st_rdy1, st_rdy2} = '0;
        {dispatch, dispatch_pc, dispatch_rd, dispatch_tag1, dispatch_tag2} = '0;
        {dispatch_data1, dispatch_data2, dispatch_rdy1, dispatch_rdy2} = '0;
        {alu_valid, alu_tag, alu_data, mul_valid, mul_tag, mul_data} = '0;
        {div_valid, div_tag, div_data, load_valid, load_tag, load_data} = '0;
        for (int s = 0; s < 4; s++) begin
            st_tag[s]  = '0;
            st_data[s] = '0;
        end

        fd = $fopen("verification/rs_mul_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/rs_mul_trace.txt");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                lines.push_back(line);
            end
            $fclose(fd);
        end

        // reset, every step in the trace, and room for the drains
        limit = 2 + 4 * `RS_DEPTH;
        foreach (lines[i]) begin
            kind = lines[i].getc(0);
            if (kind == "I" || kind == "F") begin
                n = $sscanf(lines[i], "%c %d", kind, count);
                limit += count;
            end else if (kind == "L") begin
                limit += 1;
            end else if (kind == "T") begin
                limit += 2;
            end
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_err = 0;

        foreach (lines[i]) begin
            line = lines[i];
            kind = line.getc(0);
            n = 0;
            want = 0;
            case (kind)
                "D": begin
                    want = 8;
                    n = $sscanf(line, "D %h %h %h %h %h %h %h %h", st_pc, st_rd, st_tag1,
                                st_data1, st_rdy1, st_tag2, st_data2, st_rdy2);
                    st_dispatch = 1'b1;
                end
                "B": begin
                    want = 4;
                    n = $sscanf(line, "B %d %h %h %h", num, a, b, c);
                    st_valid[num] = a[0];
                    st_tag[num]   = b;
                    st_data[num]  = c;
                end
                "I": begin
                    want = 1;
                    n = $sscanf(line, "I %d", count);
                    repeat (count) next_cycle();
                end
                "E": begin
                    want = 4;
                    n = $sscanf(line, "E %h %h %h %h", a, b, c, d);
                    expect_issue(a, b, c, d);
                end
                "F": begin
                    want = 5;
                    n = $sscanf(line, "F %d %h %h %h %h", count, a, b, c, d);
                    for (int k = 0; k < count; k++) begin
                        st_dispatch = 1'b1;
                        st_pc       = a + 4 * k;
                        st_rd       = b + k;
                        st_tag1     = c;
                        st_data1    = '0;
                        st_rdy1     = 1'b0;    // waits on the broadcast
                        st_tag2     = '0;
                        st_data2    = d + k;
                        st_rdy2     = 1'b1;
                        next_cycle();
                    end
                end
                "R": begin
                    want = 5;
                    n = $sscanf(line, "R %d %h %h %h %h", count, a, b, c, d);
                    for (int k = 0; k < count; k++) begin
                        expect_issue(a + 4 * k, b + k, c, d + k);
                    end
                end
                "L": begin
                    want = 1;
                    n = $sscanf(line, "L %h", a);
                    next_cycle();
                    @(negedge clk);
                    checks++;
                    if (rs_full !== a[0]) begin
                        $display("[ERROR] rs_full: got %h, expected %h", rs_full, a[0]);
                        errors++;
                    end
                end
                "T": begin
                    want = 1;
                    n = $sscanf(line, "T %d", num);
                    while (exp_q.size() != 0) begin
                        next_cycle();
                    end
                    repeat (2) next_cycle();    // catch late extra issues
                    collect_assert_fails();
                    tests++;
                    if (errors == test_err) begin
                        $display("test %0d done, no errors", num);
                    end else begin
                        failed_tests++;
                        $display("test %0d done, %0d errors", num, errors - test_err);
                    end
                    test_err = errors;
                end
                "#", "\n": begin
                end
                default: begin
                    $display("trace line %0d has an unknown record kind", i + 1);
                    errors++;
                end
            endcase
            if (n != want) begin
                $display("trace line %0d has the wrong number of fields", i + 1);
                errors++;
            end
        end

        collect_assert_fails();
        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rs_mul_assertions.sv
`default_nettype none

module rs_mul_assertions (
    input logic          clk,
    input logic          reset,
    input logic          rs_full,
    input logic          issue_valid,
    input rs_pkg::word_t issue_pc,
    input rs_pkg::tag_t  issue_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;    // failed assertion count

    issue_low_in_reset: assert property (@(posedge clk) $past(reset) |-> !issue_valid)
        else begin
            fails++;
            $error("issue_valid high while reset was applied");
        end

    issue_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(issue_valid))
        else begin
            fails++;
            $error("issue_valid is unknown");
        end

    // all woken together, so the head entry leaves first and frees the tail slot
    full_drops_on_issue: assert property (@(posedge clk) disable iff (reset)
        issue_valid && $past(rs_full) |-> !rs_full)
        else begin
            fails++;
            $error("rs_full stayed high after an issue from a full station");
        end

    // a second pulse must be a different entry
    issue_single_pulse: assert property (@(posedge clk) disable iff (reset)
        issue_valid && $past(issue_valid)
            |-> (issue_pc != $past(issue_pc)) || (issue_rd != $past(issue_rd)))
        else begin
            fails++;
            $error("same entry issued on two cycles");
        end

endmodule

`default_nettype wire

//--- source/rs_mul.sv
`default_nettype none

`include "rs_macros.svh"

module rs_mul (
    input  logic          clk,
    input  logic          reset,
    input  logic          dispatch,
    input  rs_pkg::word_t dispatch_pc,
    input  rs_pkg::tag_t  dispatch_rd,
    input  rs_pkg::tag_t  dispatch_tag1,
    input  rs_pkg::tag_t  dispatch_tag2,
    input  rs_pkg::word_t dispatch_data1,
    input  rs_pkg::word_t dispatch_data2,
    input  logic          dispatch_rdy1,
    input  logic          dispatch_rdy2,
    input  logic          alu_valid,
    input  rs_pkg::tag_t  alu_tag,
    input  rs_pkg::word_t alu_data,
    input  logic          mul_valid,
    input  rs_pkg::tag_t  mul_tag,
    input  rs_pkg::word_t mul_data,
    input  logic          div_valid,
    input  rs_pkg::tag_t  div_tag,
    input  rs_pkg::word_t div_data,
    input  logic          load_valid,
    input  rs_pkg::tag_t  load_tag,
    input  rs_pkg::word_t load_data,
    output logic          rs_full,
    output logic          issue_valid,
    output rs_pkg::word_t issue_pc,
    output rs_pkg::tag_t  issue_rd,
    output rs_pkg::word_t issue_data1,
    output rs_pkg::word_t issue_data2
);

    rs_pkg::operand_t     op1_in;
    rs_pkg::operand_t     op2_in;
    rs_pkg::rs_entry_t    new_entry;
    rs_pkg::rs_entry_t    entries [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] busy;
    logic [`RS_DEPTH-1:0] wake1;
    logic [`RS_DEPTH-1:0] wake2;
    rs_pkg::word_t        wake_data1 [`RS_DEPTH];
    rs_pkg::word_t        wake_data2 [`RS_DEPTH];
    rs_pkg::issue_t       issue;

    cdb_if cdb ();

    assign cdb.valid[rs_pkg::cdb_alu]  = alu_valid;
    assign cdb.tag[rs_pkg::cdb_alu]    = alu_tag;
    assign cdb.data[rs_pkg::cdb_alu]   = alu_data;
    assign cdb.valid[rs_pkg::cdb_mul]  = mul_valid;
    assign cdb.tag[rs_pkg::cdb_mul]    = mul_tag;
    assign cdb.data[rs_pkg::cdb_mul]   = mul_data;
    assign cdb.valid[rs_pkg::cdb_div]  = div_valid;
    assign cdb.tag[rs_pkg::cdb_div]    = div_tag;
    assign cdb.data[rs_pkg::cdb_div]   = div_data;
    assign cdb.valid[rs_pkg::cdb_load] = load_valid;
    assign cdb.tag[rs_pkg::cdb_load]   = load_tag;
    assign cdb.data[rs_pkg::cdb_load]  = load_data;

    assign op1_in = '{tag: dispatch_tag1, data: dispatch_data1, rdy: dispatch_rdy1};
    assign op2_in = '{tag: dispatch_tag2, data: dispatch_data2, rdy: dispatch_rdy2};

    dispatch_bypass byp0 (
        .cdb       (cdb.snoop),
        .pc        (dispatch_pc),
        .rd        (dispatch_rd),
        .op1_in    (op1_in),
        .op2_in    (op2_in),
        .entry_out (new_entry)
    );

    tag_wakeup wak0 (
        .cdb        (cdb.snoop),
        .entries    (entries),
        .busy       (busy),
        .wake1      (wake1),
        .wake2      (wake2),
        .wake_data1 (wake_data1),
        .wake_data2 (wake_data2)
    );

    rs_entry_file ent0 (
        .clk         (clk),
        .reset       (reset),
        .dispatch    (dispatch),
        .new_entry   (new_entry),
        .wake1       (wake1),
        .wake2       (wake2),
        .wake_data1  (wake_data1),
        .wake_data2  (wake_data2),
        .entries     (entries),
        .busy        (busy),
        .full        (rs_full),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    assign issue_pc    = issue.pc;
    assign issue_rd    = issue.rd;
    assign issue_data1 = issue.data1;
    assign issue_data2 = issue.data2;

endmodule

`default_nettype wire

//--- source/rs_entry_file.sv
`default_nettype none

`include "rs_macros.svh"

module rs_entry_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch,
    input  rs_pkg::rs_entry_t    new_entry,
    input  logic [`RS_DEPTH-1:0] wake1,
    input  logic [`RS_DEPTH-1:0] wake2,
    input  rs_pkg::word_t        wake_data1 [`RS_DEPTH],
    input  rs_pkg::word_t        wake_data2 [`RS_DEPTH],
    output rs_pkg::rs_entry_t    entries [`RS_DEPTH],
    output logic [`RS_DEPTH-1:0] busy,
    output logic                 full,
    output logic                 issue_valid,
    output rs_pkg::issue_t       issue
);

    logic [`RS_PTR_W-1:0] head;
    logic [`RS_PTR_W-1:0] tail;
    logic [`RS_DEPTH-1:0] ready;
    logic [`RS_DEPTH-1:0] grant;
    logic [`RS_PTR_W-1:0] grant_idx;
    logic                 accept;
    logic                 head_step;

    assign full   = busy[tail];    // next slot still occupied
    assign accept = dispatch && !full;

    // skip freed slots; also step off head == tail when older entries remain
    assign head_step = !busy[head] && (head != tail || |busy);

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready[i] = busy[i] && entries[i].op1.rdy && entries[i].op2.rdy;
        end
    end

    issue_select sel0 (
        .ready     (ready),
        .head      (head),
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (wake1[i]) begin
                entries[i].op1.data <= wake_data1[i];
                entries[i].op1.rdy  <= 1'b1;
            end
            if (wake2[i]) begin
                entries[i].op2.data <= wake_data2[i];
                entries[i].op2.rdy  <= 1'b1;
            end
        end
        if (accept) begin
            entries[tail] <= new_entry;    // tail slot is free, no wake can hit it
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= '0;
            head        <= '0;
            tail        <= '0;
            issue_valid <= 1'b0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (grant[i]) begin
                    busy[i] <= 1'b0;
                end
            end
            if (accept) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (head_step) begin
                head <= head + 1'b1;
            end
            issue_valid <= |grant;
        end
    end

    always_ff @(posedge clk) begin
        issue.pc    <= entries[grant_idx].pc;
        issue.rd    <= entries[grant_idx].rd;
        issue.data1 <= entries[grant_idx].op1.data;
        issue.data2 <= entries[grant_idx].op2.data;
    end

endmodule

`default_nettype wire

//--- source/issue_select.sv
`default_nettype none

`include "rs_macros.svh"

module issue_select (
    input  logic [`RS_DEPTH-1:0] ready,
    input  logic [`RS_PTR_W-1:0] head,
    output logic [`RS_DEPTH-1:0] grant,
    output logic [`RS_PTR_W-1:0] grant_idx
);

    // entries are allocated in order from head, so the first hit is the oldest
    always_comb begin
        logic [`RS_PTR_W-1:0] idx;
        logic                 found;

        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;

        for (int k = 0; k < `RS_DEPTH; k++) begin
            idx = head + k[`RS_PTR_W-1:0];    // wraps at depth
            if (!found && ready[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = idx;
                found      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/tag_wakeup.sv
`default_nettype none

`include "rs_macros.svh"

module tag_wakeup (
    cdb_if.snoop              cdb,
    input  rs_pkg::rs_entry_t entries [`RS_DEPTH],
    input  logic [`RS_DEPTH-1:0] busy,
    output logic [`RS_DEPTH-1:0] wake1,
    output logic [`RS_DEPTH-1:0] wake2,
    output rs_pkg::word_t     wake_data1 [`RS_DEPTH],
    output rs_pkg::word_t     wake_data2 [`RS_DEPTH]
);

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wake1[i]      = 1'b0;
            wake2[i]      = 1'b0;
            wake_data1[i] = '0;
            wake_data2[i] = '0;

            // same priority as the bypass, lowest source wins
            for (int s = `CDB_SOURCES - 1; s >= 0; s--) begin
                if (busy[i] && !entries[i].op1.rdy && cdb.valid[s]
                        && cdb.tag[s] == entries[i].op1.tag) begin
                    wake1[i]      = 1'b1;
                    wake_data1[i] = cdb.data[s];
                end
                if (busy[i] && !entries[i].op2.rdy && cdb.valid[s]
                        && cdb.tag[s] == entries[i].op2.tag) begin
                    wake2[i]      = 1'b1;
                    wake_data2[i] = cdb.data[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dispatch_bypass.sv
`default_nettype none

`include "rs_macros.svh"

module dispatch_bypass (
    cdb_if.snoop              cdb,
    input  rs_pkg::word_t     pc,
    input  rs_pkg::tag_t      rd,
    input  rs_pkg::operand_t  op1_in,
    input  rs_pkg::operand_t  op2_in,
    output rs_pkg::rs_entry_t entry_out
);

    always_comb begin
        entry_out.pc  = pc;
        entry_out.rd  = rd;
        entry_out.op1 = op1_in;
        entry_out.op2 = op2_in;

        // walk down so the lowest matching source is written last
        for (int s = `CDB_SOURCES - 1; s >= 0; s--) begin
            if (!op1_in.rdy && cdb.valid[s] && cdb.tag[s] == op1_in.tag) begin
                entry_out.op1.data = cdb.data[s];
                entry_out.op1.rdy  = 1'b1;
            end
            if (!op2_in.rdy && cdb.valid[s] && cdb.tag[s] == op2_in.tag) begin
                entry_out.op2.data = cdb.data[s];
                entry_out.op2.rdy  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cdb_if.sv
`default_nettype none

`include "rs_macros.svh"

// all result broadcasts of one cycle, indexed by rs_pkg::cdb_src_e
interface cdb_if;

    logic [`CDB_SOURCES-1:0] valid;               // one-cycle strobe per source
    rs_pkg::tag_t            tag  [`CDB_SOURCES];
    rs_pkg::word_t           data [`CDB_SOURCES];

    modport driver (
        output valid,
        output tag,
        output data
    );

    modport snoop (
        input valid,
        input tag,
        input data
    );

endinterface

`default_nettype wire

//--- source/rs_pkg.sv
`default_nettype none

`include "rs_macros.svh"

package rs_pkg;

    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`WORD_W-1:0] word_t;

    // lowest index has highest priority on a tag collision
    typedef enum logic [1:0] {
        cdb_alu  = 2'd0,
        cdb_mul  = 2'd1,
        cdb_div  = 2'd2,
        cdb_load = 2'd3
    } cdb_src_e;

    typedef struct packed {
        tag_t  tag;
        word_t data;
        logic  rdy;    // data holds the final value
    } operand_t;

    typedef struct packed {
        word_t    pc;
        tag_t     rd;
        operand_t op1;
        operand_t op2;
    } rs_entry_t;

    typedef struct packed {
        word_t pc;
        tag_t  rd;
        word_t data1;
        word_t data2;
    } issue_t;

endpackage

`default_nettype wire

//--- source/rs_macros.svh
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// station depth and index width, kept consistent by hand
`define RS_DEPTH 16
`define RS_PTR_W 4

// physical register tag
`define TAG_W 8

// data and pc
`define WORD_W 32

// alu, mul, div, load
`define CDB_SOURCES 4

`endif
